//--- common/fp_rename_settings.svh
// All counts must be powers of two because the index types wrap without extra logic
`ifndef FP_RENAME_SETTINGS_SVH
`define FP_RENAME_SETTINGS_SVH

// Architectural FP registers f0..f31
`define FP_NUM_ISA_REGS 32'd32

// Physical FP registers
// The lower half holds the reset mapping and the upper half starts out free
`define FP_NUM_PHYS_REGS 32'd64

// Map copies including the working map
// At most three can be live at once
`define FP_NUM_CHECKPOINTS 32'd4

`endif

//--- common/fp_rename_pkg.sv
// Index widths come from the settings header so the register and checkpoint counts stay powers of two
`include "fp_rename_settings.svh"

package fp_rename_pkg;

    // Architectural FP register number
    typedef logic [$clog2(`FP_NUM_ISA_REGS)-1:0] vreg_t;

    // Physical FP register number
    typedef logic [$clog2(`FP_NUM_PHYS_REGS)-1:0] preg_t;

    // Checkpoint label, wraps around the map copies
    typedef logic [$clog2(`FP_NUM_CHECKPOINTS)-1:0] ckpt_t;

    typedef logic [$clog2(`FP_NUM_CHECKPOINTS):0] ckpt_cnt_t;  // One bit wider than the label

endpackage

//--- src/fp_wb_arbiter.sv
// Requesters hold their request and payload until granted; the grant is combinational
`timescale 1ns/1ps

module fp_wb_arbiter
    import fp_rename_pkg::*;
(
    input  logic  clk_i,
    input  logic  rstn_i,
    input  logic  req0_i,                // FMA unit
    input  vreg_t vreg0_i,
    input  preg_t preg0_i,
    input  logic  req1_i,                // Divide and square root unit
    input  vreg_t vreg1_i,
    input  preg_t preg1_i,
    output logic  gnt0_o,
    output logic  gnt1_o,
    output logic  wb_valid_o,
    output vreg_t wb_vreg_o,
    output preg_t wb_preg_o
);

    logic last1_q;                        // fu1 had the last grant

    assign gnt0_o     = req0_i & (~req1_i | last1_q);
    assign gnt1_o     = req1_i & (~req0_i | ~last1_q);
    assign wb_valid_o = req0_i | req1_i;
    assign wb_vreg_o  = gnt1_o ? vreg1_i : vreg0_i;
    assign wb_preg_o  = gnt1_o ? preg1_i : preg0_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            last1_q <= 1'b1;              // fu0 first after reset
        end else if (gnt0_o) begin
            last1_q <= 1'b0;
        end else if (gnt1_o) begin
            last1_q <= 1'b1;
        end
    end

    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0({gnt0_o, gnt1_o}));

endmodule

//--- rename/fp_free_list.sv
// Holds 32 free registers at reset; every commit must return exactly one old register
`timescale 1ns/1ps
`include "fp_rename_settings.svh"

module fp_free_list
    import fp_rename_pkg::*;
(
    input  logic  clk_i,
    input  logic  rstn_i,
    input  logic  pop_i,                 // Accepted rename that writes a register
    input  logic  push_i,                // Commit frees the old mapping
    input  preg_t push_preg_i,
    input  logic  ckpt_take_i,
    input  ckpt_t ckpt_head_i,
    input  logic  do_recover_i,
    input  ckpt_t recover_checkpoint_i,
    input  logic  recover_commit_i,
    output preg_t new_preg_o,
    output logic  empty_o
);

    localparam int unsigned DEPTH = `FP_NUM_PHYS_REGS - `FP_NUM_ISA_REGS;
    localparam int unsigned PW    = $clog2(DEPTH);

    preg_t       list_q  [DEPTH];
    logic [PW:0] saved_q [`FP_NUM_CHECKPOINTS];   // Head after the checkpointing rename
    logic [PW:0] head_q;
    logic [PW:0] tail_q;
    logic [PW:0] commit_q;                        // Head as seen by committed code
    logic [PW:0] head_pop;
    logic        full;

    assign head_pop   = head_q + {{PW{1'b0}}, pop_i};
    assign new_preg_o = list_q[head_q[PW-1:0]];
    assign empty_o    = (head_q == tail_q);
    assign full       = (head_q[PW] != tail_q[PW]) && (head_q[PW-1:0] == tail_q[PW-1:0]);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                list_q[i] <= preg_t'(`FP_NUM_ISA_REGS + i);
            end
            head_q   <= '0;
            tail_q   <= {1'b1, {PW{1'b0}}};   // Full list
            commit_q <= '0;
        end else begin
            if (push_i) begin
                list_q[tail_q[PW-1:0]] <= push_preg_i;
                tail_q   <= tail_q + 1'b1;
                commit_q <= commit_q + 1'b1;
            end
            if (recover_commit_i) begin
                head_q <= commit_q + {{PW{1'b0}}, push_i};
            end else if (do_recover_i) begin
                head_q <= saved_q[recover_checkpoint_i];
            end else begin
                head_q <= head_pop;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ckpt_take_i) begin
            saved_q[ckpt_head_i] <= head_pop;
        end
    end

    // Commits can only return registers that were handed out
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rstn_i)
        push_i |-> !full);

endmodule

//--- rename/fp_rename_table.sv
// One rename and one commit per cycle; delete_checkpoint_i must only free a live checkpoint
`timescale 1ns/1ps
`include "fp_rename_settings.svh"

module fp_rename_table
    import fp_rename_pkg::*;
(
    input  logic  clk_i,
    input  logic  rstn_i,
    input  logic  rename_valid_i,
    input  vreg_t src1_i,
    input  vreg_t src2_i,
    input  vreg_t src3_i,
    input  logic  use_fs1_i,
    input  logic  use_fs2_i,
    input  logic  use_fs3_i,
    input  vreg_t dst_i,
    input  logic  write_dst_i,
    input  logic  do_checkpoint_i,
    input  preg_t new_preg_i,            // Head of the free list
    input  logic  free_empty_i,
    input  logic  wb_valid_i,
    input  vreg_t wb_vreg_i,
    input  preg_t wb_preg_i,
    input  logic  commit_valid_i,
    input  vreg_t commit_vreg_i,
    input  preg_t commit_preg_i,
    input  logic  recover_commit_i,
    input  logic  do_recover_i,
    input  ckpt_t recover_checkpoint_i,
    input  logic  delete_checkpoint_i,
    output logic  rename_valid_o,
    output preg_t src1_o,
    output preg_t src2_o,
    output preg_t src3_o,
    output preg_t old_dst_o,
    output preg_t new_dst_o,
    output logic  rdy1_o,
    output logic  rdy2_o,
    output logic  rdy3_o,
    output ckpt_t checkpoint_o,
    output logic  ckpt_take_o,
    output ckpt_t ckpt_head_o,
    output logic  stall_o,
    output logic  out_of_checkpoints_o
);

    localparam int unsigned NREG  = `FP_NUM_ISA_REGS;
    localparam int unsigned NCKPT = `FP_NUM_CHECKPOINTS;

    preg_t     map_q    [NREG][NCKPT];
    preg_t     map_d    [NREG][NCKPT];
    logic      rdy_q    [NREG][NCKPT];
    logic      rdy_d    [NREG][NCKPT];
    preg_t     commit_q [NREG];
    preg_t     commit_d [NREG];
    ckpt_t     head_q, head_d;
    ckpt_t     tail_q, tail_d;
    ckpt_cnt_t num_q, num_d;
    logic      pristine_q;                // Map still equals the reset map

    logic      accept;
    logic      rename_write;
    logic      take;
    logic      byp1, byp2, byp3;
    ckpt_t     head_next;
    ckpt_t     recover_dist;

    assign out_of_checkpoints_o = (num_q == ckpt_cnt_t'(NCKPT - 1));
    assign stall_o      = free_empty_i | (do_checkpoint_i & out_of_checkpoints_o);
    assign accept       = rename_valid_i & ~stall_o & ~do_recover_i & ~recover_commit_i;
    assign rename_write = accept & write_dst_i;
    assign take         = accept & do_checkpoint_i;
    assign ckpt_take_o  = take;
    assign ckpt_head_o  = head_q;          // Label handed out with this rename
    assign head_next    = head_q + ckpt_t'(1);
    assign recover_dist = recover_checkpoint_i - tail_q;  // Live copies behind the label

    // Same-cycle writeback bypass for the source reads
    assign byp1 = wb_valid_i & (wb_vreg_i == src1_i) & (map_q[src1_i][head_q] == wb_preg_i);
    assign byp2 = wb_valid_i & (wb_vreg_i == src2_i) & (map_q[src2_i][head_q] == wb_preg_i);
    assign byp3 = wb_valid_i & (wb_vreg_i == src3_i) & (map_q[src3_i][head_q] == wb_preg_i);

    always_comb begin
        map_d    = map_q;
        rdy_d    = rdy_q;
        commit_d = commit_q;
        head_d   = head_q;
        tail_d   = tail_q + ckpt_t'(delete_checkpoint_i);
        num_d    = num_q;
        if (commit_valid_i) begin
            commit_d[commit_vreg_i] = commit_preg_i;
        end
        if (recover_commit_i) begin
            // Exception: committed state becomes the only map
            for (int r = 0; r < NREG; r++) begin
                map_d[r][0] = commit_d[r];
                rdy_d[r][0] = 1'b1;
            end
            head_d = '0;
            tail_d = '0;
            num_d  = '0;
        end else begin
            if (wb_valid_i) begin
                for (int c = 0; c < NCKPT; c++) begin
                    if (map_q[wb_vreg_i][c] == wb_preg_i) begin
                        rdy_d[wb_vreg_i][c] = 1'b1;
                    end
                end
            end
            if (do_recover_i) begin
                head_d = recover_checkpoint_i;
                num_d  = {1'b0, recover_dist};
            end else begin
                num_d = num_q + ckpt_cnt_t'(take) - ckpt_cnt_t'(delete_checkpoint_i);
                if (take) begin
                    // Copy forward first so the rename lands in both copies
                    for (int r = 0; r < NREG; r++) begin
                        map_d[r][head_next] = map_d[r][head_q];
                        rdy_d[r][head_next] = rdy_d[r][head_q];
                    end
                    head_d = head_next;
                end
                if (rename_write) begin
                    map_d[dst_i][head_q] = new_preg_i;
                    rdy_d[dst_i][head_q] = 1'b0;
                    if (take) begin
                        map_d[dst_i][head_next] = new_preg_i;
                        rdy_d[dst_i][head_next] = 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int r = 0; r < NREG; r++) begin
                for (int c = 0; c < NCKPT; c++) begin
                    map_q[r][c] <= preg_t'(r);  // Identity map
                    rdy_q[r][c] <= 1'b1;
                end
                commit_q[r] <= preg_t'(r);
            end
            head_q         <= '0;
            tail_q         <= '0;
            num_q          <= '0;
            pristine_q     <= 1'b1;
            rename_valid_o <= 1'b0;
        end else begin
            map_q          <= map_d;
            rdy_q          <= rdy_d;
            commit_q       <= commit_d;
            head_q         <= head_d;
            tail_q         <= tail_d;
            num_q          <= num_d;
            rename_valid_o <= accept;
            if (rename_write) begin
                pristine_q <= 1'b0;
            end
        end
    end

    // Rename results, read from the map before this rename writes it
    always_ff @(posedge clk_i) begin
        if (accept) begin
            src1_o       <= map_q[src1_i][head_q];
            src2_o       <= map_q[src2_i][head_q];
            src3_o       <= map_q[src3_i][head_q];
            rdy1_o       <= rdy_q[src1_i][head_q] | ~use_fs1_i | byp1;
            rdy2_o       <= rdy_q[src2_i][head_q] | ~use_fs2_i | byp2;
            rdy3_o       <= rdy_q[src3_i][head_q] | ~use_fs3_i | byp3;
            old_dst_o    <= map_q[dst_i][head_q];
            new_dst_o    <= new_preg_i;
            checkpoint_o <= head_q;
        end
    end

    // Registers 0..31 are already ready until something has been renamed
    a_no_wb_to_reset_map: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (wb_valid_i && pristine_q) |-> (wb_preg_i >= preg_t'(NREG)));

    // Stall must keep the working copy from overrunning the oldest checkpoint
    a_ckpt_count: assert property (@(posedge clk_i) disable iff (!rstn_i)
        num_q <= ckpt_cnt_t'(NCKPT - 1));

endmodule

//--- src/fp_rename_top.sv
// Rename outputs are valid one cycle after an accepted request; recovery cycles accept no rename
`timescale 1ns/1ps

module fp_rename_top
    import fp_rename_pkg::*;
(
    input  logic  clk_i,
    input  logic  rstn_i,
    input  logic  rename_valid_i,
    input  vreg_t src1_i,
    input  vreg_t src2_i,
    input  vreg_t src3_i,
    input  logic  use_fs1_i,
    input  logic  use_fs2_i,
    input  logic  use_fs3_i,
    input  vreg_t dst_i,
    input  logic  write_dst_i,
    input  logic  do_checkpoint_i,
    input  logic  fu0_wb_valid_i,
    input  vreg_t fu0_wb_vreg_i,
    input  preg_t fu0_wb_preg_i,
    input  logic  fu1_wb_valid_i,
    input  vreg_t fu1_wb_vreg_i,
    input  preg_t fu1_wb_preg_i,
    output logic  fu0_wb_grant_o,
    output logic  fu1_wb_grant_o,
    input  logic  commit_valid_i,
    input  vreg_t commit_vreg_i,
    input  preg_t commit_preg_i,
    input  preg_t commit_old_preg_i,
    input  logic  recover_commit_i,
    input  logic  do_recover_i,
    input  ckpt_t recover_checkpoint_i,
    input  logic  delete_checkpoint_i,
    output logic  rename_valid_o,
    output preg_t src1_o,
    output preg_t src2_o,
    output preg_t src3_o,
    output logic  rdy1_o,
    output logic  rdy2_o,
    output logic  rdy3_o,
    output preg_t old_dst_o,
    output preg_t new_dst_o,
    output ckpt_t checkpoint_o,
    output logic  stall_o,
    output logic  out_of_checkpoints_o
);

    logic  wb_valid;
    vreg_t wb_vreg;
    preg_t wb_preg;
    preg_t new_preg;
    logic  free_empty;
    logic  ckpt_take;
    ckpt_t ckpt_head;
    logic  pop;

    // Recovery overrides the pop inside the free list
    assign pop = rename_valid_i & write_dst_i & ~stall_o;

    fp_wb_arbiter u_wb_arbiter (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .req0_i     (fu0_wb_valid_i),
        .vreg0_i    (fu0_wb_vreg_i),
        .preg0_i    (fu0_wb_preg_i),
        .req1_i     (fu1_wb_valid_i),
        .vreg1_i    (fu1_wb_vreg_i),
        .preg1_i    (fu1_wb_preg_i),
        .gnt0_o     (fu0_wb_grant_o),
        .gnt1_o     (fu1_wb_grant_o),
        .wb_valid_o (wb_valid),
        .wb_vreg_o  (wb_vreg),
        .wb_preg_o  (wb_preg)
    );

    fp_free_list u_free_list (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .pop_i                (pop),
        .push_i               (commit_valid_i),
        .push_preg_i          (commit_old_preg_i),
        .ckpt_take_i          (ckpt_take),
        .ckpt_head_i          (ckpt_head),
        .do_recover_i         (do_recover_i),
        .recover_checkpoint_i (recover_checkpoint_i),
        .recover_commit_i     (recover_commit_i),
        .new_preg_o           (new_preg),
        .empty_o              (free_empty)
    );

    fp_rename_table u_rename_table (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .rename_valid_i       (rename_valid_i),
        .src1_i               (src1_i),
        .src2_i               (src2_i),
        .src3_i               (src3_i),
        .use_fs1_i            (use_fs1_i),
        .use_fs2_i            (use_fs2_i),
        .use_fs3_i            (use_fs3_i),
        .dst_i                (dst_i),
        .write_dst_i          (write_dst_i),
        .do_checkpoint_i      (do_checkpoint_i),
        .new_preg_i           (new_preg),
        .free_empty_i         (free_empty),
        .wb_valid_i           (wb_valid),
        .wb_vreg_i            (wb_vreg),
        .wb_preg_i            (wb_preg),
        .commit_valid_i       (commit_valid_i),
        .commit_vreg_i        (commit_vreg_i),
        .commit_preg_i        (commit_preg_i),
        .recover_commit_i     (recover_commit_i),
        .do_recover_i         (do_recover_i),
        .recover_checkpoint_i (recover_checkpoint_i),
        .delete_checkpoint_i  (delete_checkpoint_i),
        .rename_valid_o       (rename_valid_o),
        .src1_o               (src1_o),
        .src2_o               (src2_o),
        .src3_o               (src3_o),
        .old_dst_o            (old_dst_o),
        .new_dst_o            (new_dst_o),
        .rdy1_o               (rdy1_o),
        .rdy2_o               (rdy2_o),
        .rdy3_o               (rdy3_o),
        .checkpoint_o         (checkpoint_o),
        .ckpt_take_o          (ckpt_take),
        .ckpt_head_o          (ckpt_head),
        .stall_o              (stall_o),
        .out_of_checkpoints_o (out_of_checkpoints_o)
    );

endmodule

//--- tests/tb_fp_rename.sv
// Directed table run; the model assumes in-order commits of renames that write a register
`timescale 1ns/1ps
`include "fp_rename_settings.svh"

module tb_fp_rename
    import fp_rename_pkg::*;
();

    localparam int PERIOD = 40;
    localparam int NREG   = `FP_NUM_ISA_REGS;
    localparam int NCK    = `FP_NUM_CHECKPOINTS;
    localparam int NFREE  = `FP_NUM_PHYS_REGS - `FP_NUM_ISA_REGS;

    typedef struct packed {
        logic       ren;
        logic       ckpt;
        logic       wr;
        vreg_t      s1;
        vreg_t      s2;
        vreg_t      s3;
        logic [2:0] use_m;                // Source use bits, bit 0 is fs1
        vreg_t      dst;
        logic       wb0;
        vreg_t      wb0_v;
        preg_t      wb0_p;
        logic       wb1;
        vreg_t      wb1_v;
        preg_t      wb1_p;
        logic       cmt;                  // Commit the oldest outstanding rename
        logic       rec;
        ckpt_t      rec_l;
        logic       rcm;
        logic       del;
    } step_t;

    typedef struct packed {
        vreg_t v;
        preg_t p;
        preg_t old;
    } commit_t;

    logic  clk_i, rstn_i;
    logic  rename_valid_i, use_fs1_i, use_fs2_i, use_fs3_i, write_dst_i, do_checkpoint_i;
    vreg_t src1_i, src2_i, src3_i, dst_i;
    logic  fu0_wb_valid_i, fu1_wb_valid_i, fu0_wb_grant_o, fu1_wb_grant_o;
    vreg_t fu0_wb_vreg_i, fu1_wb_vreg_i;
    preg_t fu0_wb_preg_i, fu1_wb_preg_i;
    logic  commit_valid_i, recover_commit_i, do_recover_i, delete_checkpoint_i;
    vreg_t commit_vreg_i;
    preg_t commit_preg_i, commit_old_preg_i;
    ckpt_t recover_checkpoint_i, checkpoint_o;
    logic  rename_valid_o, rdy1_o, rdy2_o, rdy3_o, stall_o, out_of_checkpoints_o;
    preg_t src1_o, src2_o, src3_o, old_dst_o, new_dst_o;

    step_t   steps [$];
    step_t   nx;
    integer  seed;
    int      wd_time;

    // Reference model state
    preg_t   map_m  [NREG];
    logic    rdy_m  [NREG];
    preg_t   cmap_m [NREG];
    preg_t   ck_map [NCK][NREG];
    logic    ck_rdy [NCK][NREG];
    int      ck_fh  [NCK];
    int      ck_rob [NCK];
    preg_t   fl_m   [NFREE];
    int      fh, ft, fc;                  // Free list head, tail and commit counts, never wrapped
    ckpt_t   head_l, tail_l;
    int      num_l;
    logic    last_fu1;
    commit_t rob [$];

    // Expected rename results for the row before
    logic    exp_valid;
    preg_t   exp_src [3];
    logic    exp_rdy [3];
    preg_t   exp_old, exp_new;
    ckpt_t   exp_ck;

    fp_rename_top dut_i (
        .clk_i (clk_i), .rstn_i (rstn_i),
        .rename_valid_i (rename_valid_i), .src1_i (src1_i), .src2_i (src2_i), .src3_i (src3_i),
        .use_fs1_i (use_fs1_i), .use_fs2_i (use_fs2_i), .use_fs3_i (use_fs3_i),
        .dst_i (dst_i), .write_dst_i (write_dst_i), .do_checkpoint_i (do_checkpoint_i),
        .fu0_wb_valid_i (fu0_wb_valid_i), .fu0_wb_vreg_i (fu0_wb_vreg_i),
        .fu0_wb_preg_i (fu0_wb_preg_i), .fu1_wb_valid_i (fu1_wb_valid_i),
        .fu1_wb_vreg_i (fu1_wb_vreg_i), .fu1_wb_preg_i (fu1_wb_preg_i),
        .fu0_wb_grant_o (fu0_wb_grant_o), .fu1_wb_grant_o (fu1_wb_grant_o),
        .commit_valid_i (commit_valid_i), .commit_vreg_i (commit_vreg_i),
        .commit_preg_i (commit_preg_i), .commit_old_preg_i (commit_old_preg_i),
        .recover_commit_i (recover_commit_i), .do_recover_i (do_recover_i),
        .recover_checkpoint_i (recover_checkpoint_i), .delete_checkpoint_i (delete_checkpoint_i),
        .rename_valid_o (rename_valid_o), .src1_o (src1_o), .src2_o (src2_o), .src3_o (src3_o),
        .rdy1_o (rdy1_o), .rdy2_o (rdy2_o), .rdy3_o (rdy3_o), .old_dst_o (old_dst_o),
        .new_dst_o (new_dst_o), .checkpoint_o (checkpoint_o), .stall_o (stall_o),
        .out_of_checkpoints_o (out_of_checkpoints_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic check_preg(input string what, input preg_t got, input preg_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "register index mismatch");
        end
    endtask

    task automatic check_ckpt(input string what, input ckpt_t got, input ckpt_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "checkpoint label mismatch");
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "status bit mismatch");
        end
    endtask

    task automatic abort_run(input string msg);
        $display("Error: %s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stimulus error");
    endtask

    // Table building, unused sources get random register numbers
    task automatic rename_req(input logic ckpt, input logic wr, input vreg_t s1, input vreg_t s2,
                              input vreg_t s3, input logic [2:0] use_m, input vreg_t dst);
        nx.ren   = 1'b1;
        nx.ckpt  = ckpt;
        nx.wr    = wr;
        nx.s1    = use_m[0] ? s1 : vreg_t'($random(seed));
        nx.s2    = use_m[1] ? s2 : vreg_t'($random(seed));
        nx.s3    = use_m[2] ? s3 : vreg_t'($random(seed));
        nx.use_m = use_m;
        nx.dst   = dst;
    endtask

    task automatic wb_req(input logic r0, input vreg_t v0, input preg_t p0,
                          input logic r1, input vreg_t v1, input preg_t p1);
        nx.wb0   = r0;
        nx.wb0_v = v0;
        nx.wb0_p = p0;
        nx.wb1   = r1;
        nx.wb1_v = v1;
        nx.wb1_p = p1;
    endtask

    task automatic end_step();
        steps.push_back(nx);
        nx = '0;
    endtask

    task automatic build_table();
        nx = '0;
        rename_req(1'b0, 1'b0, 5'd1, 5'd2, 5'd3, 3'b111, 5'd0);   // Identity map
        end_step();
        rename_req(1'b0, 1'b1, 5'd5, 5'd0, 5'd0, 3'b001, 5'd1);
        end_step();
        rename_req(1'b0, 1'b1, 5'd1, 5'd0, 5'd0, 3'b001, 5'd2);
        end_step();
        rename_req(1'b0, 1'b1, 5'd2, 5'd0, 5'd0, 3'b001, 5'd1);
        end_step();
        rename_req(1'b0, 1'b0, 5'd1, 5'd2, 5'd0, 3'b011, 5'd0);
        end_step();
        // Both units request, fu0 wins and x2 is bypassed
        wb_req(1'b1, 5'd2, 6'd33, 1'b1, 5'd1, 6'd34);
        rename_req(1'b0, 1'b0, 5'd2, 5'd1, 5'd0, 3'b011, 5'd0);
        end_step();
        wb_req(1'b0, 5'd0, 6'd0, 1'b1, 5'd1, 6'd34);              // fu1 still holding
        rename_req(1'b0, 1'b0, 5'd1, 5'd0, 5'd0, 3'b001, 5'd0);
        end_step();
        rename_req(1'b0, 1'b0, 5'd1, 5'd2, 5'd0, 3'b011, 5'd0);
        end_step();
        nx.cmt = 1'b1;
        end_step();
        nx.cmt = 1'b1;
        end_step();
        rename_req(1'b0, 1'b1, 5'd3, 5'd0, 5'd0, 3'b001, 5'd3);
        end_step();
        rename_req(1'b0, 1'b1, 5'd0, 5'd0, 5'd0, 3'b000, 5'd2);
        end_step();
        nx.rcm = 1'b1;                                             // Exception flush
        end_step();
        rename_req(1'b0, 1'b1, 5'd1, 5'd2, 5'd3, 3'b111, 5'd4);
        end_step();
        // Checkpoint, run past it and come back
        rename_req(1'b1, 1'b1, 5'd5, 5'd0, 5'd0, 3'b001, 5'd5);
        end_step();
        rename_req(1'b0, 1'b1, 5'd0, 5'd0, 5'd0, 3'b000, 5'd5);
        end_step();
        rename_req(1'b0, 1'b1, 5'd0, 5'd0, 5'd0, 3'b000, 5'd4);
        end_step();
        nx.rec   = 1'b1;
        nx.rec_l = 2'd0;
        end_step();
        rename_req(1'b0, 1'b1, 5'd5, 5'd4, 5'd0, 3'b011, 5'd6);
        end_step();
        // Run out of checkpoints
        for (int i = 0; i < 4; i++) begin
            rename_req(1'b1, 1'b1, 5'd0, 5'd0, 5'd0, 3'b000, 5'd7);
            end_step();
        end
        nx.del = 1'b1;
        end_step();
        rename_req(1'b1, 1'b1, 5'd7, 5'd0, 5'd0, 3'b001, 5'd8);
        end_step();
    endtask

    task automatic reset_model();
        for (int r = 0; r < NREG; r++) begin
            map_m[r]  = preg_t'(r);
            rdy_m[r]  = 1'b1;
            cmap_m[r] = preg_t'(r);
            for (int c = 0; c < NCK; c++) begin
                ck_map[c][r] = preg_t'(r);
                ck_rdy[c][r] = 1'b1;
            end
        end
        for (int i = 0; i < NFREE; i++) begin
            fl_m[i] = preg_t'(NREG + i);
        end
        fh       = 0;
        ft       = NFREE;
        fc       = 0;
        head_l   = '0;
        tail_l   = '0;
        num_l    = 0;
        last_fu1 = 1'b1;                  // fu0 has priority after reset
        exp_valid = 1'b0;
    endtask

    task automatic drive_step(input step_t s);
        rename_valid_i       = s.ren;
        do_checkpoint_i      = s.ckpt;
        write_dst_i          = s.wr;
        src1_i               = s.s1;
        src2_i               = s.s2;
        src3_i               = s.s3;
        use_fs1_i            = s.use_m[0];
        use_fs2_i            = s.use_m[1];
        use_fs3_i            = s.use_m[2];
        dst_i                = s.dst;
        fu0_wb_valid_i       = s.wb0;
        fu0_wb_vreg_i        = s.wb0_v;
        fu0_wb_preg_i        = s.wb0_p;
        fu1_wb_valid_i       = s.wb1;
        fu1_wb_vreg_i        = s.wb1_v;
        fu1_wb_preg_i        = s.wb1_p;
        commit_valid_i       = s.cmt;
        commit_vreg_i        = '0;
        commit_preg_i        = '0;
        commit_old_preg_i    = '0;
        if (s.cmt) begin
            if (rob.size() == 0) begin
                abort_run("commit requested with no rename outstanding");
            end
            commit_vreg_i     = rob[0].v;
            commit_preg_i     = rob[0].p;
            commit_old_preg_i = rob[0].old;
        end
        do_recover_i         = s.rec;
        recover_checkpoint_i = s.rec_l;
        recover_commit_i     = s.rcm;
        delete_checkpoint_i  = s.del;
    endtask

    function automatic logic src_ready(input vreg_t v, input logic used, input logic wbv,
                                       input vreg_t wv, input preg_t wp);
        logic bypass;
        bypass = wbv && (wv == v) && (wp == map_m[v]);  // Result lands this cycle
        return rdy_m[v] || !used || bypass;
    endfunction

    // Checks the combinational outputs, then moves the model past the next edge
    task automatic model_step(input step_t s);
        logic    stall, accept, g0, g1, wbv;
        vreg_t   wv;
        preg_t   wp;
        commit_t cm;
        stall = (fh == ft) || (s.ckpt && num_l == NCK - 1);
        g0 = 1'b0;
        g1 = 1'b0;
        if (s.wb0 && s.wb1) begin
            if (last_fu1) g0 = 1'b1;
            else g1 = 1'b1;
        end else begin
            g0 = s.wb0;
            g1 = s.wb1;
        end
        check_bit("stall_o", stall_o, stall);
        check_bit("out_of_checkpoints_o", out_of_checkpoints_o, num_l == NCK - 1);
        check_bit("fu0_wb_grant_o", fu0_wb_grant_o, g0);
        check_bit("fu1_wb_grant_o", fu1_wb_grant_o, g1);
        accept = s.ren && !stall && !s.rec && !s.rcm;
        wbv = g0 || g1;
        wv  = g1 ? s.wb1_v : s.wb0_v;
        wp  = g1 ? s.wb1_p : s.wb0_p;
        exp_valid  = accept;
        exp_src[0] = map_m[s.s1];
        exp_src[1] = map_m[s.s2];
        exp_src[2] = map_m[s.s3];
        exp_rdy[0] = src_ready(s.s1, s.use_m[0], wbv, wv, wp);
        exp_rdy[1] = src_ready(s.s2, s.use_m[1], wbv, wv, wp);
        exp_rdy[2] = src_ready(s.s3, s.use_m[2], wbv, wv, wp);
        exp_old    = map_m[s.dst];
        exp_new    = fl_m[fh % NFREE];
        exp_ck     = head_l;
        if (s.cmt) begin
            cm = rob.pop_front();
            cmap_m[cm.v] = cm.p;
            fl_m[ft % NFREE] = cm.old;    // Old mapping goes back on the free list
            ft++;
            fc++;
        end
        if (s.rcm) begin
            for (int r = 0; r < NREG; r++) begin
                map_m[r] = cmap_m[r];
                rdy_m[r] = 1'b1;
            end
            head_l = '0;
            tail_l = '0;
            num_l  = 0;
            fh     = fc;
            rob.delete();
        end else begin
            if (wbv) begin
                if (map_m[wv] == wp) rdy_m[wv] = 1'b1;
                for (int c = 0; c < NCK; c++) begin
                    if (ck_map[c][wv] == wp) ck_rdy[c][wv] = 1'b1;
                end
            end
            if (s.rec) begin
                for (int r = 0; r < NREG; r++) begin
                    map_m[r] = ck_map[s.rec_l][r];
                    rdy_m[r] = ck_rdy[s.rec_l][r];
                end
                fh     = ck_fh[s.rec_l];
                head_l = s.rec_l;
                num_l  = int'(ckpt_t'(s.rec_l - tail_l));
                while (rob.size() > ck_rob[s.rec_l]) cm = rob.pop_back();  // Squashed renames
            end else begin
                if (s.del) begin
                    tail_l++;
                    num_l--;
                end
                if (accept && s.wr) begin
                    map_m[s.dst] = exp_new;
                    rdy_m[s.dst] = 1'b0;
                    fh++;
                    cm.v   = s.dst;
                    cm.p   = exp_new;
                    cm.old = exp_old;
                    rob.push_back(cm);
                end
                if (accept && s.ckpt) begin
                    // Copy holds the state right after the checkpointing rename
                    for (int r = 0; r < NREG; r++) begin
                        ck_map[head_l][r] = map_m[r];
                        ck_rdy[head_l][r] = rdy_m[r];
                    end
                    ck_fh[head_l]  = fh;
                    ck_rob[head_l] = rob.size();
                    head_l++;
                    num_l++;
                end
            end
        end
        if (g0) last_fu1 = 1'b0;
        else if (g1) last_fu1 = 1'b1;
    endtask

    task automatic check_rename();
        check_bit("rename_valid_o", rename_valid_o, exp_valid);
        if (exp_valid) begin
            check_preg("src1_o", src1_o, exp_src[0]);
            check_preg("src2_o", src2_o, exp_src[1]);
            check_preg("src3_o", src3_o, exp_src[2]);
            check_bit("rdy1_o", rdy1_o, exp_rdy[0]);
            check_bit("rdy2_o", rdy2_o, exp_rdy[1]);
            check_bit("rdy3_o", rdy3_o, exp_rdy[2]);
            check_preg("old_dst_o", old_dst_o, exp_old);
            check_preg("new_dst_o", new_dst_o, exp_new);
            check_ckpt("checkpoint_o", checkpoint_o, exp_ck);
        end
    endtask

    initial begin
        seed   = 32'ha137;
        rstn_i = 1'b0;
        drive_step('0);
        build_table();
        reset_model();
        wd_time = (steps.size() + 20) * PERIOD;
        fork
            begin
                #(wd_time);
                $display("Timeout: the stimulus table did not complete within %0d ns", wd_time);
                $display("Simulation finished: FAIL");
                $fatal(1, "watchdog expired");
            end
        join_none
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;
        foreach (steps[i]) begin
            @(negedge clk_i);
            check_rename();
            drive_step(steps[i]);
            #(PERIOD / 4);                // Let the combinational outputs settle
            model_step(steps[i]);
        end
        @(negedge clk_i);
        check_rename();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- files.f
+incdir+common
common/fp_rename_pkg.sv
src/fp_wb_arbiter.sv
rename/fp_free_list.sv
rename/fp_rename_table.sv
src/fp_rename_top.sv
tests/tb_fp_rename.sv

//--- Bender.yml
package:
  name: fp_rename

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/fp_rename_pkg.sv
      - src/fp_wb_arbiter.sv
      - rename/fp_free_list.sv
      - rename/fp_rename_table.sv
      - src/fp_rename_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_fp_rename.sv
